// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
RTL_TOP   ?= csr_unit_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
JOBS      ?= 4
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/csr_inst_decoder.sv ====
`timescale 1ns/10ps

module csr_inst_decoder (
    input  logic                   Clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic [2:0]             in_funct3,
    input  logic [4:0]             in_rs1_idx,
    input  csr_pipe_pkg::csr_data_t in_rs1_value,
    input  csr_map_pkg::csr_addr_t  in_csr_addr,
    input  csr_pipe_pkg::csr_data_t in_pc,
    input  logic                   req_ready,
    output logic                   in_ready,
    output logic                   req_valid,
    output csr_pipe_pkg::csr_req_t  req_data
);

    import csr_map_pkg::*;
    import csr_pipe_pkg::*;

    csr_req_t req_next;

    // Stage can take a new instruction if empty or draining this cycle
    assign in_ready = !req_valid || req_ready;

    always_comb begin
        req_next         = '0;
        req_next.addr    = in_csr_addr;
        req_next.pc      = in_pc;
        req_next.illegal = 1'b0;
        // Immediate forms carry uimm in the rs1 field
        req_next.operand = in_funct3[2] ? csr_data_t'(in_rs1_idx) : in_rs1_value;
        case (in_funct3[1:0])
            2'b01: begin
                req_next.op   = CSR_OP_WRITE;
                req_next.wren = 1'b1;
            end
            2'b10: begin
                req_next.op   = CSR_OP_SET;
                req_next.wren = (in_rs1_idx != 5'd0);
            end
            2'b11: begin
                req_next.op   = CSR_OP_CLEAR;
                req_next.wren = (in_rs1_idx != 5'd0);
            end
            default: begin
                // funct3 0 and 4 are not Zicsr
                req_next.op      = CSR_OP_WRITE;
                req_next.wren    = 1'b0;
                req_next.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (in_ready) begin
            req_valid <= in_valid;
        end
    end

    always_ff @(posedge Clk) begin
        if (in_valid && in_ready) begin
            req_data <= req_next;
        end
    end

endmodule

// ==== hw/csr_map_pkg.sv ====
package csr_map_pkg;

    typedef logic [11:0] csr_addr_t;

    // ====================
    // Machine-mode CSR addresses
    // ====================
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_MINSTRETH = 12'hB82;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // Same encoding as funct3[1:0] of the Zicsr instructions
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_t;

    localparam int unsigned CAUSE_ILLEGAL_INST = 2;

    // MXL = 1 (32 bit) with only the I extension
    localparam logic [31:0] MISA_VALUE = 32'h4000_0100;

    // Address bits [11:10] == 2'b11 mark a read-only CSR
    function automatic logic csr_is_read_only(input csr_addr_t addr);
        return (addr[11:10] == 2'b11);
    endfunction

endpackage

// ==== hw/csr_pipe_pkg.sv ====
package csr_pipe_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] csr_data_t;

    // One decoded CSR instruction on its way to the register file
    typedef struct packed {
        csr_map_pkg::csr_op_t   op;
        csr_map_pkg::csr_addr_t addr;
        // rs1 value or zero-extended uimm
        csr_data_t              operand;
        // Low for set/clear with rs1 index 0
        logic                   wren;
        // Bad funct3 seen in decode
        logic                   illegal;
        csr_data_t              pc;
    } csr_req_t;

endpackage

// ==== hw/csr_reg_file.sv ====
`timescale 1ns/10ps

module csr_reg_file #(
    parameter csr_pipe_pkg::csr_data_t HART_ID = '0
) (
    input  logic                    Clk,
    input  logic                    rst,
    input  logic                    exe_valid,
    input  csr_pipe_pkg::csr_req_t  exe_data,
    input  logic                    out_ready,
    output logic                    exe_ready,
    output logic                    out_valid,
    output csr_pipe_pkg::csr_data_t out_rdata,
    output logic                    out_trap,
    output csr_pipe_pkg::csr_data_t mepc
);

    import csr_map_pkg::*;
    import csr_pipe_pkg::*;

    csr_data_t   mstatus;
    csr_data_t   mie;
    csr_data_t   mtvec;
    csr_data_t   mscratch;
    csr_data_t   mcause;
    csr_data_t   mtval;
    logic [63:0] instret;

    csr_data_t old_value;
    csr_data_t new_value;
    logic      addr_known;
    logic      trap;
    logic      fire;

    // Accept when the response slot is free or being drained
    assign exe_ready = !out_valid || out_ready;
    assign fire      = exe_valid && exe_ready;

    // ====================
    // Read side
    // ====================
    always_comb begin
        addr_known = 1'b1;
        old_value  = '0;
        case (exe_data.addr)
            CSR_MSTATUS:   old_value = mstatus;
            CSR_MISA:      old_value = MISA_VALUE;
            CSR_MIE:       old_value = mie;
            CSR_MTVEC:     old_value = mtvec;
            CSR_MSCRATCH:  old_value = mscratch;
            CSR_MEPC:      old_value = mepc;
            CSR_MCAUSE:    old_value = mcause;
            CSR_MTVAL:     old_value = mtval;
            CSR_MINSTRET:  old_value = instret[31:0];
            CSR_MINSTRETH: old_value = instret[63:32];
            CSR_MHARTID:   old_value = HART_ID;
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MIMPID:    old_value = '0;
            default:       addr_known = 1'b0;
        endcase
    end

    always_comb begin
        case (exe_data.op)
            CSR_OP_SET:   new_value = old_value | exe_data.operand;
            CSR_OP_CLEAR: new_value = old_value & ~exe_data.operand;
            default:      new_value = exe_data.operand;
        endcase
    end

    assign trap = exe_data.illegal || !addr_known
               || (exe_data.wren && csr_is_read_only(exe_data.addr));

    // ====================
    // Update side
    // ====================
    always_ff @(posedge Clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            mstatus   <= '0;
            mie       <= '0;
            mtvec     <= '0;
            mscratch  <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mtval     <= '0;
            instret   <= '0;
        end else begin
            if (exe_ready) begin
                out_valid <= exe_valid;
            end
            if (fire && trap) begin
                mcause <= csr_data_t'(CAUSE_ILLEGAL_INST);
                mepc   <= exe_data.pc;
                mtval  <= csr_data_t'(exe_data.addr);
            end else if (fire) begin
                instret <= instret + 64'd1;
                if (exe_data.wren) begin
                    case (exe_data.addr)
                        CSR_MSTATUS:   mstatus  <= new_value;
                        CSR_MIE:       mie      <= new_value;
                        CSR_MTVEC:     mtvec    <= new_value;
                        CSR_MSCRATCH:  mscratch <= new_value;
                        CSR_MEPC:      mepc     <= new_value;
                        CSR_MCAUSE:    mcause   <= new_value;
                        CSR_MTVAL:     mtval    <= new_value;
                        // Written half stands and skips the increment
                        CSR_MINSTRET:  instret  <= {instret[63:32], new_value};
                        CSR_MINSTRETH: instret  <= {new_value, instret[31:0]};
                        // Writes to misa are dropped
                        default: ;
                    endcase
                end
            end
        end
    end

    // Response payload
    always_ff @(posedge Clk) begin
        if (fire) begin
            out_rdata <= trap ? '0 : old_value;
            out_trap  <= trap;
        end
    end

endmodule

// ==== hw/csr_req_fifo.sv ====
`timescale 1ns/10ps

module csr_req_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic Clk,
    input  logic rst,
    input  logic wr_valid,
    input  T     wr_data,
    input  logic rd_ready,
    output logic wr_ready,
    output logic rd_valid,
    output T     rd_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          wr_fire;
    logic          rd_fire;

    assign wr_ready = (count != CW'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    // Pointers and occupancy
    always_ff @(posedge Clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== hw/csr_unit_top.sv ====
`timescale 1ns/10ps

module csr_unit_top #(
    parameter int unsigned             FIFO_DEPTH = 4,
    parameter csr_pipe_pkg::csr_data_t HART_ID    = '0
) (
    input  logic                    Clk,
    input  logic                    rst,
    // Instruction stream
    input  logic                    in_valid,
    input  logic [2:0]              in_funct3,
    input  logic [4:0]              in_rs1_idx,
    input  csr_pipe_pkg::csr_data_t in_rs1_value,
    input  csr_map_pkg::csr_addr_t  in_csr_addr,
    input  csr_pipe_pkg::csr_data_t in_pc,
    output logic                    in_ready,
    // Response stream
    output logic                    out_valid,
    output csr_pipe_pkg::csr_data_t out_rdata,
    output logic                    out_trap,
    input  logic                    out_ready,
    output csr_pipe_pkg::csr_data_t mepc
);

    import csr_pipe_pkg::*;

    logic     req_valid;
    logic     req_ready;
    csr_req_t req_data;
    logic     exe_valid;
    logic     exe_ready;
    csr_req_t exe_data;

    csr_inst_decoder u_decoder (
        .Clk          (Clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_funct3    (in_funct3),
        .in_rs1_idx   (in_rs1_idx),
        .in_rs1_value (in_rs1_value),
        .in_csr_addr  (in_csr_addr),
        .in_pc        (in_pc),
        .req_ready    (req_ready),
        .in_ready     (in_ready),
        .req_valid    (req_valid),
        .req_data     (req_data)
    );

    // Absorbs bursts while the response side is stalled
    csr_req_fifo #(
        .T     (csr_req_t),
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .Clk      (Clk),
        .rst      (rst),
        .wr_valid (req_valid),
        .wr_data  (req_data),
        .rd_ready (exe_ready),
        .wr_ready (req_ready),
        .rd_valid (exe_valid),
        .rd_data  (exe_data)
    );

    csr_reg_file #(
        .HART_ID (HART_ID)
    ) u_regs (
        .Clk       (Clk),
        .rst       (rst),
        .exe_valid (exe_valid),
        .exe_data  (exe_data),
        .out_ready (out_ready),
        .exe_ready (exe_ready),
        .out_valid (out_valid),
        .out_rdata (out_rdata),
        .out_trap  (out_trap),
        .mepc      (mepc)
    );

endmodule

// ==== testbench/csr_input.txt ====
# Columns (hex): funct3 rs1_idx rs1_value csr_addr pc expected_rdata expected_trap
# Instructions run in file order; HART_ID is 3
1 05 a5a5a5a5 340 00000100 00000000 0
2 06 0000000f 340 00000104 a5a5a5a5 0
3 07 000000a0 340 00000108 a5a5a5af 0
2 00 ffffffff 340 0000010c a5a5a50f 0
6 00 00000000 340 00000110 a5a5a50f 0
5 1f 00000000 305 00000114 00000000 0
7 03 00000000 305 00000118 0000001f 0
6 00 00000000 305 0000011c 0000001c 0
1 02 00000888 304 00000120 00000000 0
3 04 00000008 304 00000124 00000888 0
7 00 00000000 304 00000128 00000880 0
2 00 00000000 f11 0000012c 00000000 0
2 00 00000000 f12 00000130 00000000 0
2 00 00000000 f13 00000134 00000000 0
2 00 00000000 f14 00000138 00000003 0
2 00 00000000 301 0000013c 40000100 0
1 01 12345678 f14 00000140 00000000 1
2 00 00000000 342 00000144 00000002 0
2 00 00000000 341 00000148 00000140 0
2 00 00000000 343 0000014c 00000f14 0
4 01 00000001 340 00000150 00000000 1
2 00 00000000 7c0 00000154 00000000 1
2 00 00000000 343 00000158 000007c0 0
2 00 00000000 b02 0000015c 00000014 0
1 0a 00000100 b02 00000160 00000015 0
2 00 00000000 b02 00000164 00000100 0
2 00 00000000 b02 00000168 00000101 0
2 00 00000000 b82 0000016c 00000000 0
2 00 00000000 340 00000170 a5a5a50f 0
0 00 00000000 300 00000174 00000000 1
2 00 00000000 341 00000178 00000174 0

// ==== testbench/csr_unit_props.sv ====
`timescale 1ns/10ps

module csr_unit_props (
    input logic                    clk,
    input logic                    rst,
    input logic                    in_ready,
    input logic                    out_valid,
    input logic                    out_ready,
    input csr_pipe_pkg::csr_data_t out_rdata,
    input logic                    out_trap
);

    // Response slot empty while in reset
    a_reset_no_resp: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during reset");

    // Stalled response holds its payload
    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_rdata) && $stable(out_trap))
        else $error("response changed while out_ready was low");

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else $error("in_ready low in the first cycle after reset");

endmodule

bind csr_unit_top csr_unit_props u_props (
    .clk       (Clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rdata (out_rdata),
    .out_trap  (out_trap)
);

// ==== testbench/csr_unit_tb.sv ====
`timescale 1ns/10ps

module csr_unit_tb;

    import csr_map_pkg::*;
    import csr_pipe_pkg::*;

    localparam int unsigned FIFO_DEPTH = 4;
    localparam csr_data_t   HART_ID    = 32'h3;
    localparam int          WAIT_LIMIT = 200;

    // One line of the stimulus file
    typedef struct packed {
        logic [2:0] funct3;
        logic [4:0] rs1_idx;
        csr_data_t  rs1_value;
        csr_addr_t  csr_addr;
        csr_data_t  pc;
        csr_data_t  exp_rdata;
        logic       exp_trap;
    } vector_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid;
    logic [2:0] in_funct3;
    logic [4:0] in_rs1_idx;
    csr_data_t in_rs1_value;
    csr_addr_t in_csr_addr;
    csr_data_t in_pc;
    logic      in_ready;
    logic      out_valid;
    csr_data_t out_rdata;
    logic      out_trap;
    logic      out_ready;
    csr_data_t mepc;

    vector_t     vectors[$];
    vector_t     expected[$];
    logic [31:0] gap_state;
    logic [31:0] rdy_state;
    int          resp_count;

    csr_unit_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .HART_ID    (HART_ID)
    ) u_csr_unit_top (
        .Clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_funct3    (in_funct3),
        .in_rs1_idx   (in_rs1_idx),
        .in_rs1_value (in_rs1_value),
        .in_csr_addr  (in_csr_addr),
        .in_pc        (in_pc),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_rdata    (out_rdata),
        .out_trap     (out_trap),
        .out_ready    (out_ready),
        .mepc         (mepc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_fail(input string why);
        $display("ERROR: %s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    // ====================
    // Compare tasks
    // ====================
    task automatic check_rdata(input csr_data_t got, input csr_data_t want, input int idx);
        if (got !== want) begin
            $display("MISMATCH t=%0t response %0d rdata got %08h expected %08h",
                     $time, idx, got, want);
            stop_with_fail("wrong read data");
        end
    endtask

    task automatic check_trap(input logic got, input logic want, input int idx);
        if (got !== want) begin
            $display("MISMATCH t=%0t response %0d trap got %0b expected %0b",
                     $time, idx, got, want);
            stop_with_fail("wrong trap flag");
        end
    endtask

    task automatic check_mepc(input csr_data_t got, input csr_data_t want, input int idx);
        if (got !== want) begin
            $display("MISMATCH t=%0t response %0d mepc port got %08h expected %08h",
                     $time, idx, got, want);
            stop_with_fail("wrong mepc after trap");
        end
    endtask

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        logic [2:0] f3;
        logic [4:0] idx;
        csr_data_t  val;
        csr_addr_t  addr;
        csr_data_t  pc;
        csr_data_t  rd;
        logic       tr;
        vector_t    v;
        fd = $fopen("testbench/csr_input.txt", "r");
        if (fd == 0) begin
            stop_with_fail("cannot open testbench/csr_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Skip blank and comment lines
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", f3, idx, val, addr, pc, rd, tr);
                    if (n == 7) begin
                        v = '{f3, idx, val, addr, pc, rd, tr};
                        vectors.push_back(v);
                    end else if (n > 0) begin
                        stop_with_fail("malformed line in stimulus file");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Drive one instruction and hold it until the decoder takes it
    task automatic send_instr(input vector_t v);
        int waited;
        in_valid     = 1'b1;
        in_funct3    = v.funct3;
        in_rs1_idx   = v.rs1_idx;
        in_rs1_value = v.rs1_value;
        in_csr_addr  = v.csr_addr;
        in_pc        = v.pc;
        waited       = 0;
        while (!in_ready) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > WAIT_LIMIT) begin
                stop_with_fail("timeout waiting for in_ready");
            end
        end
        expected.push_back(v);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Random back-pressure with each transfer known half a cycle ahead
    task automatic watch_responses();
        vector_t want;
        forever begin
            @(negedge clk);
            rdy_state = lcg_next(rdy_state);
            out_ready = rdy_state[16];
            if (out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    stop_with_fail("response arrived with no request outstanding");
                end
                want = expected.pop_front();
                check_rdata(out_rdata, want.exp_rdata, resp_count);
                check_trap(out_trap, want.exp_trap, resp_count);
                if (want.exp_trap) begin
                    check_mepc(mepc, want.pc, resp_count);
                end
                resp_count = resp_count + 1;
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int waited;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_funct3    = '0;
        in_rs1_idx   = '0;
        in_rs1_value = '0;
        in_csr_addr  = '0;
        in_pc        = '0;
        out_ready    = 1'b0;
        gap_state    = 32'd8;
        rdy_state    = 32'd8;
        resp_count   = 0;
        load_vectors();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        fork
            watch_responses();
        join_none
        foreach (vectors[i]) begin
            gap_state = lcg_next(gap_state);
            if (gap_state[17:16] == 2'b00) begin
                repeat (1 + gap_state[19:18]) @(negedge clk);
            end
            send_instr(vectors[i]);
        end
        waited = 0;
        while (expected.size() != 0) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > WAIT_LIMIT) begin
                stop_with_fail("timeout waiting for out_valid");
            end
        end
        // Room for a stray extra response to show up
        repeat (8) @(negedge clk);
        if (!out_valid) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_fail("extra response after the last expected one");
        end
    end

endmodule

// ==== vlog.f ====
hw/csr_map_pkg.sv
hw/csr_pipe_pkg.sv
hw/csr_inst_decoder.sv
hw/csr_req_fifo.sv
hw/csr_reg_file.sv
hw/csr_unit_top.sv
testbench/csr_unit_props.sv
testbench/csr_unit_tb.sv
